// File: design/wb_macros.svh
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// data word, also the width of one fill beat and one W beat.
`define WB_XLEN 64

// physical byte address.
`define WB_PADDR 32

// line geometry. one line is one W burst.
`define WB_LINE_WORDS 4
`define WB_WORD_IDX_W 2
`define WB_LINE_OFF 5
`define WB_LINE_ADDR_W (`WB_PADDR - `WB_LINE_OFF)

// replace queue slots.
`define WB_RQ_DEPTH 4
`define WB_RQ_IDX_W 2

`endif

// File: design/wb_pkg.sv
`include "wb_macros.svh"

package wb_pkg;

    typedef logic [`WB_XLEN-1:0] wb_word_t;
    typedef logic [`WB_LINE_ADDR_W-1:0] wb_laddr_t;
    typedef logic [`WB_RQ_IDX_W-1:0] wb_idx_t;

    // a whole victim line, word 0 first in the stream.
    typedef wb_word_t [`WB_LINE_WORDS-1:0] wb_line_t;

    localparam int WB_HDR_PAD_W = `WB_XLEN - 1 - `WB_RQ_IDX_W - `WB_LINE_ADDR_W;

    // first beat of a victim stream.
    typedef struct packed {
        logic [WB_HDR_PAD_W-1:0] rsvd;
        logic dirty;
        wb_idx_t idx;       // slot handed out at allocation.
        wb_laddr_t line_addr;
    } wb_hdr_t;

    // header or data word, depending on the beat's place in the stream.
    typedef union packed {
        wb_hdr_t hdr;
        wb_word_t data;
    } wb_beat_u;

endpackage

// File: design/fill_decode.sv
`include "wb_macros.svh"

module fill_decode import wb_pkg::*; (
    input  logic clk,
    input  logic rst,

    input  logic fill_valid,
    output logic fill_ready,
    input  wb_beat_u fill_beat,

    output logic commit_en,
    output wb_idx_t commit_idx,
    output logic commit_dirty,
    output wb_laddr_t commit_addr,
    output wb_line_t commit_line
);

    logic in_data;      // header seen, data words follow.
    logic [`WB_WORD_IDX_W-1:0] widx;
    logic beat_fire;
    logic last_word;
    wb_idx_t idx_q;
    logic dirty_q;
    wb_laddr_t addr_q;
    wb_line_t line_q;

    // the stream pauses for the commit cycle.
    assign fill_ready = ~commit_en;
    assign beat_fire = fill_valid & fill_ready;
    assign last_word = (widx == `WB_WORD_IDX_W'(`WB_LINE_WORDS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_data <= 1'b0;
            widx <= '0;
            commit_en <= 1'b0;
        end else begin
            commit_en <= 1'b0;
            if (beat_fire) begin
                if (!in_data) begin
                    in_data <= 1'b1;
                    widx <= '0;
                end else begin
                    widx <= widx + 1'b1;
                    if (last_word) begin
                        in_data <= 1'b0;
                        commit_en <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire) begin
            if (!in_data) begin
                idx_q <= fill_beat.hdr.idx;
                dirty_q <= fill_beat.hdr.dirty;
                addr_q <= fill_beat.hdr.line_addr;
            end else begin
                line_q[widx] <= fill_beat.data;   // arrival order.
            end
        end
    end

    assign commit_idx = idx_q;
    assign commit_dirty = dirty_q;
    assign commit_addr = addr_q;
    assign commit_line = line_q;

endmodule

// File: design/replace_queue.sv
`include "wb_macros.svh"

module replace_queue import wb_pkg::*; (
    input  logic clk,
    input  logic rst,

    input  logic alloc_valid,
    output logic alloc_ready,
    output wb_idx_t alloc_idx,

    input  logic commit_en,
    input  wb_idx_t commit_idx,
    input  logic commit_dirty,
    input  wb_laddr_t commit_addr,
    input  wb_line_t commit_line,

    input  logic [`WB_PADDR-1:0] probe_addr,
    output logic probe_hit,

    output logic wb_valid,
    input  logic wb_ready,
    output wb_laddr_t wb_addr,
    output wb_line_t wb_line,
    input  logic wb_done
);

    wb_idx_t head;
    wb_idx_t tail;
    logic head_wrap;
    logic tail_wrap;
    logic full;
    logic empty;

    logic [`WB_RQ_DEPTH-1:0] committed;
    logic [`WB_RQ_DEPTH-1:0] dirty;
    logic issued;       // head line is with the writer.

    wb_laddr_t addr_mem [`WB_RQ_DEPTH];
    wb_line_t line_mem [`WB_RQ_DEPTH];

    logic head_ready;
    logic clean_retire;
    logic retire;

    wb_laddr_t probe_line;
    logic [`WB_RQ_DEPTH-1:0] hit;

    // same index, different lap means every slot is held.
    assign full = (head == tail) & (head_wrap != tail_wrap);
    assign empty = (head == tail) & (head_wrap == tail_wrap);

    assign alloc_ready = ~full;
    assign alloc_idx = tail;

    assign head_ready = ~empty & committed[head];
    assign clean_retire = head_ready & ~dirty[head];
    assign retire = clean_retire | wb_done;

    assign wb_valid = head_ready & dirty[head] & ~issued;
    assign wb_addr = addr_mem[head];
    assign wb_line = line_mem[head];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            head_wrap <= 1'b0;
            tail_wrap <= 1'b0;
            committed <= '0;
            dirty <= '0;
            issued <= 1'b0;
        end else begin
            if (alloc_valid & alloc_ready) begin
                {tail_wrap, tail} <= {tail_wrap, tail} + 1'b1;
            end

            // slots fill out of order, by the index in the header.
            if (commit_en) begin
                committed[commit_idx] <= 1'b1;
                dirty[commit_idx] <= commit_dirty;
            end

            if (wb_valid & wb_ready) begin
                issued <= 1'b1;
            end

            // in-order retirement at the head only.
            if (retire) begin
                committed[head] <= 1'b0;
                dirty[head] <= 1'b0;
                issued <= 1'b0;
                {head_wrap, head} <= {head_wrap, head} + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit_en) begin
            addr_mem[commit_idx] <= commit_addr;
            line_mem[commit_idx] <= commit_line;
        end
    end

    // store conflict: any dirty line not yet acknowledged by B.
    assign probe_line = probe_addr[`WB_PADDR-1:`WB_LINE_OFF];

    always_comb begin
        for (int i = 0; i < `WB_RQ_DEPTH; i++) begin
            hit[i] = committed[i] & dirty[i] & (addr_mem[i] == probe_line);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            probe_hit <= 1'b0;
        end else begin
            probe_hit <= |hit;
        end
    end

endmodule

// File: design/axi_wb_writer.sv
`include "wb_macros.svh"

module axi_wb_writer import wb_pkg::*; (
    input  logic clk,
    input  logic rst,

    input  logic wb_valid,
    output logic wb_ready,
    input  wb_laddr_t wb_addr,
    input  wb_line_t wb_line,
    output logic wb_done,

    output logic aw_valid,
    input  logic aw_ready,
    output logic [`WB_PADDR-1:0] aw_addr,

    output logic w_valid,
    input  logic w_ready,
    output logic [`WB_XLEN-1:0] w_data,
    output logic w_last,

    input  logic b_valid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } state_e;

    state_e state;
    logic [`WB_WORD_IDX_W-1:0] widx;
    wb_laddr_t addr_q;
    wb_line_t line_q;
    logic take;

    assign wb_ready = (state == S_IDLE);
    assign take = wb_valid & wb_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            widx <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (take) begin
                        state <= S_ADDR;
                        widx <= '0;
                    end
                end
                S_ADDR: begin
                    if (aw_ready) state <= S_DATA;
                end
                S_DATA: begin
                    if (w_ready) begin
                        widx <= widx + 1'b1;
                        if (w_last) state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (b_valid) state <= S_IDLE;   // next line only after B.
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            addr_q <= wb_addr;
            line_q <= wb_line;
        end
    end

    assign aw_valid = (state == S_ADDR);
    assign aw_addr = {addr_q, {`WB_LINE_OFF{1'b0}}};     // line aligned.

    assign w_valid = (state == S_DATA);
    assign w_data = line_q[widx];
    assign w_last = (widx == `WB_WORD_IDX_W'(`WB_LINE_WORDS - 1));

    assign wb_done = (state == S_RESP) & b_valid;

endmodule

// File: design/dcache_wb_top.sv
`include "wb_macros.svh"

module dcache_wb_top import wb_pkg::*; (
    input  logic clk,
    input  logic rst,

    input  logic alloc_valid,
    output logic alloc_ready,
    output wb_idx_t alloc_idx,

    input  logic fill_valid,
    output logic fill_ready,
    input  wb_beat_u fill_beat,

    input  logic [`WB_PADDR-1:0] probe_addr,
    output logic probe_hit,

    output logic aw_valid,
    input  logic aw_ready,
    output logic [`WB_PADDR-1:0] aw_addr,
    output logic w_valid,
    input  logic w_ready,
    output logic [`WB_XLEN-1:0] w_data,
    output logic w_last,
    input  logic b_valid
);

    logic commit_en;
    wb_idx_t commit_idx;
    logic commit_dirty;
    wb_laddr_t commit_addr;
    wb_line_t commit_line;

    logic wb_valid;
    logic wb_ready;
    wb_laddr_t wb_addr;
    wb_line_t wb_line;
    logic wb_done;

    fill_decode u_fill_decode (
        .clk          (clk),
        .rst          (rst),
        .fill_valid   (fill_valid),
        .fill_ready   (fill_ready),
        .fill_beat    (fill_beat),
        .commit_en    (commit_en),
        .commit_idx   (commit_idx),
        .commit_dirty (commit_dirty),
        .commit_addr  (commit_addr),
        .commit_line  (commit_line)
    );

    replace_queue u_replace_queue (
        .clk          (clk),
        .rst          (rst),
        .alloc_valid  (alloc_valid),
        .alloc_ready  (alloc_ready),
        .alloc_idx    (alloc_idx),
        .commit_en    (commit_en),
        .commit_idx   (commit_idx),
        .commit_dirty (commit_dirty),
        .commit_addr  (commit_addr),
        .commit_line  (commit_line),
        .probe_addr   (probe_addr),
        .probe_hit    (probe_hit),
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .wb_addr      (wb_addr),
        .wb_line      (wb_line),
        .wb_done      (wb_done)
    );

    axi_wb_writer u_axi_wb_writer (
        .clk      (clk),
        .rst      (rst),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_addr  (wb_addr),
        .wb_line  (wb_line),
        .wb_done  (wb_done),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw_addr  (aw_addr),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w_data   (w_data),
        .w_last   (w_last),
        .b_valid  (b_valid)
    );

endmodule

// File: dv/wb_assert.sv
`include "wb_macros.svh"

module wb_assert (
    input logic clk,
    input logic rst,
    input logic aw_valid,
    input logic aw_ready,
    input logic [`WB_PADDR-1:0] aw_addr,
    input logic w_valid,
    input logic w_ready,
    input logic [`WB_XLEN-1:0] w_data,
    input logic w_last,
    input logic alloc_valid,
    input logic alloc_ready,
    input logic retire
);
    timeunit 1ns;
    timeprecision 100ps;

    logic aw_seen;      // AW of the current burst accepted.
    logic [`WB_RQ_IDX_W:0] held;    // allocated slots not yet retired.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_seen <= 1'b0;
        end else if (aw_valid && aw_ready) begin
            aw_seen <= 1'b1;
        end else if (w_valid && w_ready && w_last) begin
            aw_seen <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held <= '0;
        end else if (alloc_valid && alloc_ready && !retire) begin
            held <= held + 1'b1;
        end else if (!(alloc_valid && alloc_ready) && retire) begin
            held <= held - 1'b1;
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("aw_valid or aw_addr changed before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_last))
        else $error("w_valid, w_data or w_last changed before w_ready");

    w_after_aw: assert property (@(posedge clk) disable iff (rst)
        $rose(w_valid) |-> aw_seen)
        else $error("w_valid rose with no accepted AW for the burst");

    full_stall: assert property (@(posedge clk) disable iff (rst)
        alloc_ready == (held != (`WB_RQ_IDX_W+1)'(`WB_RQ_DEPTH)))
        else $error("alloc_ready does not match the number of held slots");

endmodule

// File: dv/wb_checker.sv
`include "wb_macros.svh"

module wb_checker import wb_pkg::*; (
    input logic clk,
    input logic rst,
    input logic alloc_valid,
    input logic alloc_ready,
    input wb_idx_t alloc_idx,
    input logic fill_valid,
    input logic fill_ready,
    input wb_beat_u fill_beat,
    input logic [`WB_PADDR-1:0] probe_addr,
    input logic probe_hit,
    input logic aw_valid,
    input logic aw_ready,
    input logic [`WB_PADDR-1:0] aw_addr,
    input logic w_valid,
    input logic w_ready,
    input logic [`WB_XLEN-1:0] w_data,
    input logic w_last,
    input logic b_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    int errors = 0;
    int n_done;
    int n_alloc;
    int beat_no;
    int w_beat;
    int pend_cnt;
    wb_laddr_t exp_addr_q [$];
    wb_line_t exp_line_q [$];
    wb_laddr_t visible_q [$];   // dirty lines a store must not pass.
    logic cur_dirty;
    wb_laddr_t cur_addr;
    wb_laddr_t pend_addr;
    wb_line_t cur_line;
    wb_line_t burst_line;
    logic in_burst;
    logic exp_hit;
    logic hit_armed;
    logic fill_gap;     // commit cycle, the stream is held off.
    wb_laddr_t exp_addr;

    function automatic logic in_visible(input logic [`WB_PADDR-1:0] addr);
        foreach (visible_q[i]) begin
            if (visible_q[i] == addr[`WB_PADDR-1:`WB_LINE_OFF]) return 1'b1;
        end
        return 1'b0;
    endfunction

    // sampled mid-cycle, each handshake completes at the next rising edge.
    always @(negedge clk) begin
        if (rst) begin
            n_done = 0;
            n_alloc = 0;
            beat_no = 0;
            pend_cnt = 0;
            in_burst = 1'b0;
            hit_armed = 1'b0;
            fill_gap = 1'b0;
            exp_addr_q.delete();
            exp_line_q.delete();
            visible_q.delete();
        end else begin
            if (hit_armed && probe_hit !== exp_hit) begin
                $display("ERROR %0t: probe_hit %b, expected %b", $time, probe_hit, exp_hit);
                errors++;
            end
            if (fill_ready !== !fill_gap) begin
                $display("ERROR %0t: fill_ready %b, expected %b", $time, fill_ready,
                         !fill_gap);
                errors++;
            end
            fill_gap = 1'b0;
            if (pend_cnt > 0) begin
                pend_cnt--;
                if (pend_cnt == 0) visible_q.push_back(pend_addr);
            end
            exp_hit = in_visible(probe_addr);
            hit_armed = 1'b1;

            if (alloc_valid && alloc_ready) begin
                if (alloc_idx !== wb_idx_t'(n_alloc)) begin
                    $display("ERROR %0t: alloc_idx %0d, expected %0d", $time, alloc_idx,
                             wb_idx_t'(n_alloc));
                    errors++;
                end
                n_alloc++;
            end

            if (fill_valid && fill_ready) begin
                if (beat_no == 0) begin
                    cur_dirty = fill_beat.hdr.dirty;
                    cur_addr = fill_beat.hdr.line_addr;
                end else begin
                    cur_line[beat_no-1] = fill_beat.data;
                end
                if (beat_no == `WB_LINE_WORDS) begin
                    beat_no = 0;
                    fill_gap = 1'b1;
                    if (cur_dirty) begin
                        exp_addr_q.push_back(cur_addr);
                        exp_line_q.push_back(cur_line);
                        pend_cnt = 2;   // written one edge after the commit strobe.
                        pend_addr = cur_addr;
                    end
                end else begin
                    beat_no++;
                end
            end

            if (aw_valid && aw_ready) begin
                if (exp_addr_q.size() == 0) begin
                    $display("burst with no pending dirty line at time %0t", $time);
                    errors++;
                end else begin
                    exp_addr = exp_addr_q.pop_front();
                    burst_line = exp_line_q.pop_front();
                    if (aw_addr !== {exp_addr, `WB_LINE_OFF'(0)}) begin
                        $display("ERROR %0t: aw_addr %h, expected %h", $time, aw_addr,
                                 {exp_addr, `WB_LINE_OFF'(0)});
                        errors++;
                    end
                    in_burst = 1'b1;
                    w_beat = 0;
                end
            end

            if (w_valid && w_ready) begin
                if (!in_burst) begin
                    $display("W beat outside any burst at time %0t", $time);
                    errors++;
                end else begin
                    if (w_data !== burst_line[w_beat] ||
                        w_last !== (w_beat == `WB_LINE_WORDS - 1)) begin
                        $display("ERROR %0t: beat %0d data %h last %b, expected %h", $time,
                                 w_beat, w_data, w_last, burst_line[w_beat]);
                        errors++;
                    end
                    w_beat++;
                    if (w_beat == `WB_LINE_WORDS) in_burst = 1'b0;
                end
            end

            // the line stays visible through the probe of the B edge.
            if (b_valid) begin
                n_done++;
                if (visible_q.size() > 0) void'(visible_q.pop_front());
            end
        end
    end

endmodule

// File: dv/wb_tb.sv
`include "wb_macros.svh"

module wb_tb import wb_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_VICTIMS = 200;
    localparam int CYCLE_LIMIT = N_VICTIMS * 40 + 100;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic alloc_valid = 1'b0;
    logic alloc_ready;
    wb_idx_t alloc_idx;
    logic fill_valid = 1'b0;
    logic fill_ready;
    wb_beat_u fill_beat = '0;
    logic [`WB_PADDR-1:0] probe_addr = '0;
    logic probe_hit;
    logic aw_valid;
    logic aw_ready = 1'b0;
    logic [`WB_PADDR-1:0] aw_addr;
    logic w_valid;
    logic w_ready = 1'b0;
    logic [`WB_XLEN-1:0] w_data;
    logic w_last;
    logic b_valid = 1'b0;

    integer seed = 5;
    int cycles = 0;
    int n_dirty = 0;
    int b_wait = 0;
    int stall = 0;
    logic wlast_seen = 1'b0;
    wb_laddr_t recent [4] = '{default: '0};

    always #50 clk = ~clk;

    dcache_wb_top u_dcache_wb_top (.*);

    wb_checker u_checker (.*);

    bind dcache_wb_top wb_assert u_wb_assert (
        .*,
        .retire (u_replace_queue.retire)
    );

    task automatic put_beat(input wb_beat_u beat);
        fill_valid <= 1'b1;
        fill_beat <= beat;
        do @(negedge clk); while (!fill_ready);
        @(posedge clk);
    endtask

    task automatic send_victim(input int n);
        wb_beat_u hb;
        wb_laddr_t la;
        logic dirty;
        int gap;
        dirty = $random(seed) & 1;
        if (n > 0 && ($random(seed) & 3) == 0) la = recent[$unsigned($random(seed)) % 4];
        else la = wb_laddr_t'($random(seed));
        recent[n % 4] = la;
        alloc_valid <= 1'b1;
        do @(negedge clk); while (!alloc_ready);
        @(posedge clk);
        alloc_valid <= 1'b0;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clk);
        hb = '0;
        hb.hdr.dirty = dirty;
        hb.hdr.idx = wb_idx_t'(n);     // slots are handed out in turn.
        hb.hdr.line_addr = la;
        put_beat(hb);
        for (int w = 0; w < `WB_LINE_WORDS; w++) begin
            hb.data = {$random(seed), $random(seed)};
            put_beat(hb);
        end
        fill_valid <= 1'b0;
        if (dirty) n_dirty++;
    endtask

    initial begin
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < N_VICTIMS; n++) send_victim(n);
        while (u_checker.n_done < n_dirty) @(posedge clk);
        @(posedge clk);     // let the last probe answer land.
        $display("errors: %0d", u_checker.errors);
        if (u_checker.errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if ($random(seed) & 1) probe_addr <= $random(seed);
            else probe_addr <= {recent[$unsigned($random(seed)) % 4],
                                `WB_LINE_OFF'($random(seed))};
        end
    end

    always @(negedge clk) wlast_seen = w_valid & w_ready & w_last;

    // AXI slave, with occasional long stalls so the queue fills up.
    always @(posedge clk) begin
        if (rst) begin
            aw_ready <= 1'b0;
            w_ready <= 1'b0;
            b_valid <= 1'b0;
            b_wait <= 0;
            stall <= 0;
        end else begin
            if (stall > 0) begin
                stall <= stall - 1;
            end else if ($unsigned($random(seed)) % 64 == 0) begin
                stall <= 20 + $unsigned($random(seed)) % 20;
            end
            aw_ready <= (stall == 0) && (($random(seed) & 3) != 0);
            w_ready <= (stall == 0) && (($random(seed) & 3) != 0);
            b_valid <= (b_wait == 1);
            if (wlast_seen) b_wait <= 1 + $unsigned($random(seed)) % 4;
            else if (b_wait > 0) b_wait <= b_wait - 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run not done after %0d cycles, errors: %0d", CYCLE_LIMIT,
                     u_checker.errors);
            $display("tests failed");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+design
design/wb_pkg.sv
design/fill_decode.sv
design/replace_queue.sv
design/axi_wb_writer.sv
design/dcache_wb_top.sv
dv/wb_assert.sv
dv/wb_checker.sv
dv/wb_tb.sv

// File: Bender.yml
package:
  name: dcache_wb

export_include_dirs:
  - design

sources:
  - design/wb_pkg.sv
  - design/fill_decode.sv
  - design/replace_queue.sv
  - design/axi_wb_writer.sv
  - design/dcache_wb_top.sv
  - target: test
    files:
      - dv/wb_assert.sv
      - dv/wb_checker.sv
      - dv/wb_tb.sv
